// File: csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

  // ==================================================
  // Machine CSR addresses
  // ==================================================
  localparam logic [11:0] csr_mstatus    = 12'h300;
  localparam logic [11:0] csr_misa       = 12'h301;
  localparam logic [11:0] csr_medeleg    = 12'h302;
  localparam logic [11:0] csr_mideleg    = 12'h303;
  localparam logic [11:0] csr_mie        = 12'h304;
  localparam logic [11:0] csr_mtvec      = 12'h305;
  localparam logic [11:0] csr_mcounteren = 12'h306;
  localparam logic [11:0] csr_mscratch   = 12'h340;
  localparam logic [11:0] csr_mepc       = 12'h341;
  localparam logic [11:0] csr_mcause     = 12'h342;
  localparam logic [11:0] csr_mtval      = 12'h343;
  localparam logic [11:0] csr_mip        = 12'h344;
  localparam logic [11:0] csr_mcycle     = 12'hB00;
  localparam logic [11:0] csr_minstret   = 12'hB02;
  localparam logic [11:0] csr_mcycleh    = 12'hB80;
  localparam logic [11:0] csr_minstreth  = 12'hB82;

  // ==================================================
  // Writable bits and reset values
  // ==================================================
  localparam logic [31:0] mstatus_mask = 32'h807F_F9BB; // 31, 22:11, 8:7, 5:3, 1:0.
  localparam logic [31:0] misa_mask    = 32'hC3FF_FFFF; // MXL and extensions.
  localparam logic [31:0] mie_mask     = 32'h0000_0BBB; // Shared with mip.

  localparam logic [31:0] misa_reset  = 32'h4000_0100; // RV32I.
  localparam logic [31:0] mtvec_reset = 32'h0000_0100; // Direct mode.

  localparam logic [3:0] cause_illegal_instr = 4'd2;

endpackage

`default_nettype wire

// File: sys_instr_pkg.sv
`default_nettype none

package sys_instr_pkg;

  // ==================================================
  // SYSTEM opcode and function codes
  // ==================================================
  localparam logic [6:0] opcode_system = 7'b111_0011;

  localparam logic [2:0] f3_priv   = 3'd0;
  localparam logic [2:0] f3_csrrw  = 3'd1;
  localparam logic [2:0] f3_csrrs  = 3'd2;
  localparam logic [2:0] f3_csrrc  = 3'd3;
  localparam logic [2:0] f3_csrrwi = 3'd5;
  localparam logic [2:0] f3_csrrsi = 3'd6;
  localparam logic [2:0] f3_csrrci = 3'd7;

  localparam logic [11:0] funct12_mret = 12'h302;

  // One word, two decodings.
  typedef union packed {
    struct packed {
      logic [11:0] csr_addr;
      logic [4:0]  uimm;     // rs1 index or zimm.
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } csr;
    struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } priv;
  } sys_instr_u;

  // ==================================================
  // Execution sequencer states
  // ==================================================
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_exec    = 2'd1;
  localparam logic [1:0] st_done    = 2'd2;
  localparam logic [1:0] st_release = 2'd3;

endpackage

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [11:0] rd_addr,
  input  logic        wr_en,
  input  logic [11:0] wr_addr,
  input  logic [31:0] wr_data,
  input  logic        trap_en,
  input  logic [31:0] trap_epc,
  input  logic [31:0] trap_tval,
  input  logic [3:0]  trap_cause,
  input  logic        mret_en,
  input  logic        retire,
  output logic        rd_valid,
  output logic [31:0] rd_value,
  output logic [31:0] mepc,
  output logic [31:0] trap_vector
);

  logic [31:0] mstatus;
  logic [31:0] misa;
  logic [31:0] medeleg;
  logic [31:0] mideleg;
  logic [31:0] mie;
  logic [31:0] mtvec;
  logic [31:0] mcounteren;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mip;
  logic [63:0] mcycle;
  logic [63:0] minstret;

  // ==================================================
  // Read side
  // ==================================================
  always_comb begin
    rd_valid = 1'b1;
    case (rd_addr)
      csr_map_pkg::csr_mstatus:    rd_value = mstatus & csr_map_pkg::mstatus_mask;
      csr_map_pkg::csr_misa:       rd_value = misa & csr_map_pkg::misa_mask;
      csr_map_pkg::csr_medeleg:    rd_value = medeleg;
      csr_map_pkg::csr_mideleg:    rd_value = mideleg;
      csr_map_pkg::csr_mie:        rd_value = mie & csr_map_pkg::mie_mask;
      csr_map_pkg::csr_mtvec:      rd_value = mtvec;
      csr_map_pkg::csr_mcounteren: rd_value = mcounteren;
      csr_map_pkg::csr_mscratch:   rd_value = mscratch;
      csr_map_pkg::csr_mepc:       rd_value = mepc;
      csr_map_pkg::csr_mcause:     rd_value = mcause;
      csr_map_pkg::csr_mtval:      rd_value = mtval;
      csr_map_pkg::csr_mip:        rd_value = mip & csr_map_pkg::mie_mask;
      csr_map_pkg::csr_mcycle:     rd_value = mcycle[31:0];
      csr_map_pkg::csr_mcycleh:    rd_value = mcycle[63:32];
      csr_map_pkg::csr_minstret:   rd_value = minstret[31:0];
      csr_map_pkg::csr_minstreth:  rd_value = minstret[63:32];
      default: begin
        rd_valid = 1'b0; // Unmapped address.
        rd_value = 32'h0;
      end
    endcase
  end

  // Vectored mode offsets the base by four times the cause.
  always_comb begin
    if (mtvec[1:0] == 2'd1) begin
      trap_vector = {mtvec[31:2] + {26'b0, mcause[3:0]}, 2'b00};
    end else begin
      trap_vector = {mtvec[31:2], 2'b00};
    end
  end

  // ==================================================
  // Register updates
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus    <= 32'h0;
      misa       <= csr_map_pkg::misa_reset;
      medeleg    <= 32'h0;
      mideleg    <= 32'h0;
      mie        <= 32'h0;
      mtvec      <= csr_map_pkg::mtvec_reset;
      mcounteren <= 32'h0;
      mscratch   <= 32'h0;
      mepc       <= 32'h0;
      mcause     <= 32'h0;
      mtval      <= 32'h0;
      mip        <= 32'h0;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          csr_map_pkg::csr_mstatus:    mstatus <= wr_data & csr_map_pkg::mstatus_mask;
          csr_map_pkg::csr_misa:       misa <= wr_data & csr_map_pkg::misa_mask;
          csr_map_pkg::csr_medeleg:    medeleg <= wr_data;
          csr_map_pkg::csr_mideleg:    mideleg <= wr_data;
          csr_map_pkg::csr_mie:        mie <= wr_data & csr_map_pkg::mie_mask;
          csr_map_pkg::csr_mtvec:      mtvec <= wr_data;
          csr_map_pkg::csr_mcounteren: mcounteren <= wr_data;
          csr_map_pkg::csr_mscratch:   mscratch <= wr_data;
          csr_map_pkg::csr_mepc:       mepc <= wr_data;
          csr_map_pkg::csr_mcause:     mcause <= wr_data;
          csr_map_pkg::csr_mtval:      mtval <= wr_data;
          csr_map_pkg::csr_mip:        mip <= wr_data & csr_map_pkg::mie_mask;
          default: ;
        endcase
      end
      if (trap_en) begin
        mstatus[7] <= mstatus[3]; // MPIE takes MIE.
        mstatus[3] <= 1'b0;
        mepc       <= trap_epc;
        mtval      <= trap_tval;
        mcause     <= {28'b0, trap_cause};
      end
      if (mret_en) begin
        mstatus[3] <= mstatus[7]; // MIE takes MPIE.
        mstatus[7] <= 1'b0;
      end
    end
  end

  // Counters.
  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle   <= 64'h0;
      minstret <= 64'h0;
    end else begin
      if (wr_en && wr_addr == csr_map_pkg::csr_mcycle) begin
        mcycle[31:0] <= wr_data;
      end else if (wr_en && wr_addr == csr_map_pkg::csr_mcycleh) begin
        mcycle[63:32] <= wr_data;
      end else begin
        mcycle <= mcycle + 64'd1;
      end
      if (retire) begin
        minstret <= minstret + 64'd1; // Retire beats a write.
      end else if (wr_en && wr_addr == csr_map_pkg::csr_minstret) begin
        minstret[31:0] <= wr_data;
      end else if (wr_en && wr_addr == csr_map_pkg::csr_minstreth) begin
        minstret[63:32] <= wr_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: sys_exec.sv
`timescale 1ns/1ns
`default_nettype none

module sys_exec (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  logic [31:0] instr,
  input  logic [31:0] pc,
  input  logic [31:0] rs1_data,
  output logic        ack,
  output logic [31:0] rd_data,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output logic        trap,
  output logic [11:0] rd_addr,
  output logic        wr_en,
  output logic [11:0] wr_addr,
  output logic [31:0] wr_data,
  output logic        trap_en,
  output logic [31:0] trap_epc,
  output logic [31:0] trap_tval,
  output logic [3:0]  trap_cause,
  output logic        mret_en,
  input  logic        rd_valid,
  input  logic [31:0] rd_value,
  input  logic [31:0] mepc,
  input  logic [31:0] trap_vector
);

  sys_instr_pkg::sys_instr_u instr_q;
  logic [1:0]  state;
  logic [31:0] src;
  logic [31:0] new_value;
  logic        do_write;
  logic        is_mret;
  logic        illegal;
  logic        in_exec;

  // ==================================================
  // Decode and read-modify-write
  // ==================================================
  always_comb begin
    src       = instr_q.csr.funct3[2] ? {27'b0, instr_q.csr.uimm} : rs1_data;
    new_value = src;
    do_write  = 1'b0;
    is_mret   = 1'b0;
    illegal   = instr_q.csr.opcode != sys_instr_pkg::opcode_system;
    case (instr_q.csr.funct3)
      sys_instr_pkg::f3_csrrw, sys_instr_pkg::f3_csrrwi: begin
        do_write = 1'b1;
      end
      sys_instr_pkg::f3_csrrs, sys_instr_pkg::f3_csrrsi: begin
        new_value = rd_value | src;
        do_write  = instr_q.csr.uimm != 5'd0; // Zero source is read only.
      end
      sys_instr_pkg::f3_csrrc, sys_instr_pkg::f3_csrrci: begin
        new_value = rd_value & ~src;
        do_write  = instr_q.csr.uimm != 5'd0;
      end
      sys_instr_pkg::f3_priv: begin
        is_mret = instr_q.priv.funct12 == sys_instr_pkg::funct12_mret &&
                  instr_q.priv.rs1 == 5'd0 && instr_q.priv.rd == 5'd0;
        illegal = illegal || !is_mret;
      end
      default: illegal = 1'b1; // Reserved funct3.
    endcase
    if (instr_q.csr.funct3 != sys_instr_pkg::f3_priv && !rd_valid) begin
      illegal = 1'b1;
    end
  end

  assign in_exec    = state == sys_instr_pkg::st_exec;
  assign rd_addr    = instr_q.csr.csr_addr;
  assign wr_addr    = instr_q.csr.csr_addr;
  assign wr_data    = new_value;
  assign wr_en      = in_exec && do_write && !illegal;
  assign mret_en    = in_exec && is_mret && !illegal;
  assign trap_en    = in_exec && illegal;
  assign trap_epc   = pc;
  assign trap_tval  = instr_q;
  assign trap_cause = csr_map_pkg::cause_illegal_instr;

  // ==================================================
  // Handshake sequencer
  // ==================================================
  always_ff @(posedge clk) begin
    if (!rst) begin
      state    <= sys_instr_pkg::st_idle;
      ack      <= 1'b0;
      redirect <= 1'b0;
      trap     <= 1'b0;
    end else begin
      case (state)
        sys_instr_pkg::st_idle: begin
          if (req) begin
            state <= sys_instr_pkg::st_exec;
          end
        end
        sys_instr_pkg::st_exec: begin
          trap     <= illegal;
          redirect <= illegal || is_mret;
          state    <= sys_instr_pkg::st_done;
        end
        sys_instr_pkg::st_done: begin
          ack   <= 1'b1;
          state <= sys_instr_pkg::st_release;
        end
        default: begin
          if (!req) begin
            ack   <= 1'b0; // Requester has let go.
            state <= sys_instr_pkg::st_idle;
          end
        end
      endcase
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (state == sys_instr_pkg::st_idle && req) begin
      instr_q <= instr;
    end
    if (in_exec) begin
      rd_data <= (illegal || is_mret) ? 32'h0 : rd_value; // Old value.
    end
    if (state == sys_instr_pkg::st_done) begin
      redirect_pc <= trap ? trap_vector : (redirect ? mepc : 32'h0);
    end
  end

endmodule

`default_nettype wire

// File: csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  logic [31:0] instr,
  input  logic [31:0] pc,
  input  logic [31:0] rs1_data,
  input  logic        retire,
  output logic        ack,
  output logic [31:0] rd_data,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output logic        trap
);

  logic [11:0] rd_addr;
  logic        wr_en;
  logic [11:0] wr_addr;
  logic [31:0] wr_data;
  logic        trap_en;
  logic [31:0] trap_epc;
  logic [31:0] trap_tval;
  logic [3:0]  trap_cause;
  logic        mret_en;
  logic        rd_valid;
  logic [31:0] rd_value;
  logic [31:0] mepc;
  logic [31:0] trap_vector;

  sys_exec u_exec (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .ack         (ack),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .trap        (trap),
    .rd_addr     (rd_addr),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .trap_en     (trap_en),
    .trap_epc    (trap_epc),
    .trap_tval   (trap_tval),
    .trap_cause  (trap_cause),
    .mret_en     (mret_en),
    .rd_valid    (rd_valid),
    .rd_value    (rd_value),
    .mepc        (mepc),
    .trap_vector (trap_vector)
  );

  csr_file u_file (
    .clk         (clk),
    .rst         (rst),
    .rd_addr     (rd_addr),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .trap_en     (trap_en),
    .trap_epc    (trap_epc),
    .trap_tval   (trap_tval),
    .trap_cause  (trap_cause),
    .mret_en     (mret_en),
    .retire      (retire),
    .rd_valid    (rd_valid),
    .rd_value    (rd_value),
    .mepc        (mepc),
    .trap_vector (trap_vector)
  );

endmodule

`default_nettype wire

// File: csr_unit_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_assertions (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic redirect,
  input logic trap,
  input logic trap_en,
  input logic mret_en
);

  a_ack_after_reset: assert property (@(posedge clk) !rst |=> !ack)
    else $error("ack high in the cycle after reset");

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst) $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  // Response held until the requester lets go.
  a_ack_held: assert property (@(posedge clk) disable iff (!rst) ack && req |=> ack)
    else $error("ack fell while req was still high");

  // A redirect comes from exactly one trap or mret pulse in the exec cycle.
  a_one_redirect: assert property (@(posedge clk) disable iff (!rst)
      $rose(ack) && redirect |-> trap == $past(trap_en, 2) && !trap == $past(mret_en, 2))
    else $error("redirect response does not match a single trap or mret pulse");

endmodule

bind csr_unit csr_unit_assertions u_assert (
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .ack      (ack),
  .redirect (redirect),
  .trap     (trap),
  .trap_en  (trap_en),
  .mret_en  (mret_en)
);

`default_nettype wire

// File: csr_checker.sv
`timescale 1ns/1ns
`default_nettype none

module csr_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        ack,
  input  logic [31:0] rd_data,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        trap,
  input  logic [31:0] exp_rd_data,
  input  logic        exp_redirect,
  input  logic [31:0] exp_redirect_pc,
  input  logic        exp_trap,
  input  logic [1:0]  exp_kind,
  output int          error_count,
  output int          check_count
);

  logic        ack_q;
  logic [31:0] first_cycle;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
      error_count = error_count + 1;
    end
  endtask

  // ==================================================
  // Compare on each rising ack, mid-cycle
  // ==================================================
  always @(negedge clk) begin
    if (!rst) begin
      ack_q       = 1'b0;
      first_cycle = 32'h0;
      error_count = 0;
      check_count = 0;
    end else begin
      if (ack && !ack_q) begin
        check_count = check_count + 1;
        case (exp_kind)
          2'd1: first_cycle = rd_data; // First mcycle sample.
          2'd2: begin
            if (rd_data <= first_cycle) begin
              $display("FAILED rd_data: got %h, expected above %h at %0t",
                       rd_data, first_cycle, $time);
              error_count = error_count + 1;
            end
          end
          default: compare_value("rd_data", rd_data, exp_rd_data);
        endcase
        compare_value("redirect", {31'b0, redirect}, {31'b0, exp_redirect});
        compare_value("trap", {31'b0, trap}, {31'b0, exp_trap});
        if (exp_redirect) begin
          compare_value("redirect_pc", redirect_pc, exp_redirect_pc);
        end
      end
      ack_q = ack;
    end
  end

endmodule

`default_nettype wire

// File: tb_csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csr_unit;

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic        retire;
  logic        ack;
  logic [31:0] rd_data;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        trap;

  logic [31:0] exp_rd_data;
  logic        exp_redirect;
  logic [31:0] exp_redirect_pc;
  logic        exp_trap;
  logic [1:0]  exp_kind;
  int          error_count;
  int          check_count;
  int          timeouts;

  // One entry per request; kind 1 and 2 are the two mcycle reads.
  logic [31:0] tbl_instr[$];
  logic [31:0] tbl_pc[$];
  logic [31:0] tbl_rs1[$];
  int          tbl_retires[$];
  logic [1:0]  tbl_kind[$];
  logic [31:0] tbl_rd[$];
  logic        tbl_redirect[$];
  logic [31:0] tbl_rpc[$];
  logic        tbl_trap[$];

  csr_unit u_dut (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .retire      (retire),
    .ack         (ack),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .trap        (trap)
  );

  csr_checker u_chk (
    .clk             (clk),
    .rst             (rst),
    .ack             (ack),
    .rd_data         (rd_data),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .trap            (trap),
    .exp_rd_data     (exp_rd_data),
    .exp_redirect    (exp_redirect),
    .exp_redirect_pc (exp_redirect_pc),
    .exp_trap        (exp_trap),
    .exp_kind        (exp_kind),
    .error_count     (error_count),
    .check_count     (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // Instruction encoding and table building
  // ==================================================
  function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr,
                                           input logic [4:0] uimm);
    sys_instr_pkg::sys_instr_u w;
    w.csr.csr_addr = addr;
    w.csr.uimm     = uimm;
    w.csr.funct3   = f3;
    w.csr.rd       = 5'd5;
    w.csr.opcode   = sys_instr_pkg::opcode_system;
    return w;
  endfunction

  function automatic logic [31:0] priv_word(input logic [11:0] funct12);
    sys_instr_pkg::sys_instr_u w;
    w.priv.funct12 = funct12;
    w.priv.rs1     = 5'd0;
    w.priv.funct3  = sys_instr_pkg::f3_priv;
    w.priv.rd      = 5'd0;
    w.priv.opcode  = sys_instr_pkg::opcode_system;
    return w;
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [31:0] at_pc,
                           input logic [31:0] src, input int retires, input logic [1:0] kind,
                           input logic [31:0] rd, input logic redir, input logic [31:0] rpc,
                           input logic is_trap);
    tbl_instr.push_back(word);
    tbl_pc.push_back(at_pc);
    tbl_rs1.push_back(src);
    tbl_retires.push_back(retires);
    tbl_kind.push_back(kind);
    tbl_rd.push_back(rd);
    tbl_redirect.push_back(redir);
    tbl_rpc.push_back(rpc);
    tbl_trap.push_back(is_trap);
  endtask

  task automatic add_csr(input logic [31:0] word, input logic [31:0] src, input logic [31:0] rd);
    add_entry(word, 32'h0000_1000, src, 0, 2'd0, rd, 1'b0, 32'h0, 1'b0);
  endtask

  task automatic add_read(input logic [11:0] addr, input logic [31:0] rd);
    add_csr(csr_word(sys_instr_pkg::f3_csrrs, addr, 5'd0), 32'h0, rd);
  endtask

  task automatic add_redirect(input logic [31:0] word, input logic [31:0] at_pc,
                              input logic [31:0] rpc, input logic is_trap);
    add_entry(word, at_pc, 32'h0, 0, 2'd0, 32'h0, 1'b1, rpc, is_trap);
  endtask

  task automatic build_table();
    logic [2:0]  rw = sys_instr_pkg::f3_csrrw;
    logic [2:0]  rs = sys_instr_pkg::f3_csrrs;
    logic [2:0]  rc = sys_instr_pkg::f3_csrrc;
    logic [2:0]  rwi = sys_instr_pkg::f3_csrrwi;
    logic [2:0]  rsi = sys_instr_pkg::f3_csrrsi;
    logic [2:0]  rci = sys_instr_pkg::f3_csrrci;
    logic [31:0] bad_word;
    bad_word = csr_word(rs, 12'h7C0, 5'd0); // Unmapped address.
    add_read(csr_map_pkg::csr_misa, 32'h4000_0100); // RV32I.
    add_read(csr_map_pkg::csr_mtvec, 32'h0000_0100);
    add_read(csr_map_pkg::csr_mscratch, 32'h0);
    add_read(csr_map_pkg::csr_mepc, 32'h0);
    add_read(csr_map_pkg::csr_mcause, 32'h0);
    add_csr(csr_word(rw, csr_map_pkg::csr_mscratch, 5'd1), 32'h1234_5678, 32'h0);
    add_csr(csr_word(rs, csr_map_pkg::csr_mscratch, 5'd1), 32'h0000_F00F, 32'h1234_5678);
    add_csr(csr_word(rc, csr_map_pkg::csr_mscratch, 5'd2), 32'h1200_000F, 32'h1234_F67F);
    add_csr(csr_word(rwi, csr_map_pkg::csr_mscratch, 5'h15), 32'hFFFF_0000, 32'h0034_F670);
    add_csr(csr_word(rsi, csr_map_pkg::csr_mscratch, 5'h0A), 32'hFFFF_0000, 32'h0000_0015);
    add_csr(csr_word(rci, csr_map_pkg::csr_mscratch, 5'h03), 32'hFFFF_0000, 32'h0000_001F);
    add_csr(csr_word(rc, csr_map_pkg::csr_mscratch, 5'd0), 32'hFFFF_FFFF, 32'h0000_001C);
    add_read(csr_map_pkg::csr_mscratch, 32'h0000_001C); // x0 clear left it alone.
    add_csr(csr_word(rw, csr_map_pkg::csr_mepc, 5'd1), 32'h8000_0040, 32'h0);
    add_csr(csr_word(rsi, csr_map_pkg::csr_mepc, 5'h03), 32'h0, 32'h8000_0040);
    add_csr(csr_word(rci, csr_map_pkg::csr_mepc, 5'h01), 32'h0, 32'h8000_0043);
    add_read(csr_map_pkg::csr_mepc, 32'h8000_0042);
    // Writable mstatus bits 31, 22:11, 8:7, 5:3, 1:0 and mie/mip bits 11, 9:7, 5:3, 1:0.
    add_csr(csr_word(rw, csr_map_pkg::csr_mstatus, 5'd1), 32'hFFFF_FFFF, 32'h0);
    add_read(csr_map_pkg::csr_mstatus, 32'h807F_F9BB);
    add_csr(csr_word(rw, csr_map_pkg::csr_mie, 5'd1), 32'hFFFF_FFFF, 32'h0);
    add_read(csr_map_pkg::csr_mie, 32'h0000_0BBB);
    add_csr(csr_word(rw, csr_map_pkg::csr_mip, 5'd1), 32'hFFFF_FFFF, 32'h0);
    add_read(csr_map_pkg::csr_mip, 32'h0000_0BBB);
    add_csr(csr_word(rw, csr_map_pkg::csr_misa, 5'd1), 32'hFFFF_FFFF, 32'h4000_0100);
    add_read(csr_map_pkg::csr_misa, 32'hC3FF_FFFF);
    add_csr(csr_word(rw, csr_map_pkg::csr_mstatus, 5'd1), 32'h0000_0008, 32'h807F_F9BB);
    add_redirect(bad_word, 32'h0000_2000, 32'h0000_0100, 1'b1); // Direct vector.
    add_read(csr_map_pkg::csr_mcause, 32'd2);
    add_read(csr_map_pkg::csr_mepc, 32'h0000_2000);
    add_read(csr_map_pkg::csr_mtval, bad_word);
    add_read(csr_map_pkg::csr_mstatus, 32'h0000_0080); // MPIE from MIE.
    add_csr(csr_word(rw, csr_map_pkg::csr_mtvec, 5'd1), 32'h0000_0201, 32'h0000_0100);
    add_redirect(priv_word(12'h000), 32'h0000_3000, 32'h0000_0208, 1'b1); // ecall in vectored mode.
    add_read(csr_map_pkg::csr_mepc, 32'h0000_3000);
    add_read(csr_map_pkg::csr_mtval, 32'h0000_0073);
    add_read(csr_map_pkg::csr_mcause, 32'd2);
    add_read(csr_map_pkg::csr_mstatus, 32'h0);
    add_csr(csr_word(rw, csr_map_pkg::csr_mepc, 5'd1), 32'h0000_4444, 32'h0000_3000);
    add_csr(csr_word(rw, csr_map_pkg::csr_mstatus, 5'd1), 32'h0000_0080, 32'h0);
    add_redirect(priv_word(sys_instr_pkg::funct12_mret), 32'h0000_5000, 32'h0000_4444, 1'b0);
    add_read(csr_map_pkg::csr_mstatus, 32'h0000_0008); // MIE restored and MPIE clear.
    add_csr(csr_word(rw, csr_map_pkg::csr_minstret, 5'd1), 32'h0, 32'h0);
    add_entry(csr_word(rs, csr_map_pkg::csr_minstret, 5'd0), 32'h0000_1000, 32'h0, 5, 2'd0,
              32'd5, 1'b0, 32'h0, 1'b0);
    add_entry(csr_word(rs, csr_map_pkg::csr_mcycle, 5'd0), 32'h0000_1000, 32'h0, 0, 2'd1,
              32'h0, 1'b0, 32'h0, 1'b0);
    add_entry(csr_word(rs, csr_map_pkg::csr_mcycle, 5'd0), 32'h0000_1000, 32'h0, 0, 2'd2,
              32'h0, 1'b0, 32'h0, 1'b0);
  endtask

  // ==================================================
  // Driving
  // ==================================================
  task automatic apply_retires(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      retire <= 1'b1;
      @(posedge clk);
      retire <= 1'b0;
    end
  endtask

  task automatic run_request(input int idx);
    int cycles;
    @(posedge clk);
    req             <= 1'b1;
    instr           <= tbl_instr[idx];
    pc              <= tbl_pc[idx];
    rs1_data        <= tbl_rs1[idx];
    exp_rd_data     <= tbl_rd[idx];
    exp_redirect    <= tbl_redirect[idx];
    exp_redirect_pc <= tbl_rpc[idx];
    exp_trap        <= tbl_trap[idx];
    exp_kind        <= tbl_kind[idx];
    cycles = 0;
    while (!ack && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    if (!ack) begin
      $display("Timeout: no ack within 50 cycles for entry %0d", idx);
      timeouts++;
    end
    req <= 1'b0;
    cycles = 0;
    while (ack && cycles < 50) begin
      @(posedge clk);
      cycles++;
    end
    if (ack) begin
      $display("Timeout: ack still high 50 cycles after req fell, entry %0d", idx);
      timeouts++;
    end
  endtask

  initial begin
    rst             = 1'b0;
    req             = 1'b0;
    instr           = 32'h0;
    pc              = 32'h0;
    rs1_data        = 32'h0;
    retire          = 1'b0;
    exp_rd_data     = 32'h0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = 32'h0;
    exp_trap        = 1'b0;
    exp_kind        = 2'd0;
    timeouts        = 0;
    build_table();
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < tbl_instr.size(); i++) begin
      apply_retires(tbl_retires[i]);
      run_request(i);
      if (timeouts != 0) begin
        break;
      end
    end
    repeat (2) @(posedge clk);
    $display("Responses %0d of %0d, compare errors %0d, timeouts %0d",
             check_count, tbl_instr.size(), error_count, timeouts);
    if (error_count == 0 && timeouts == 0 && check_count == tbl_instr.size()) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_unit.f
csr_map_pkg.sv
sys_instr_pkg.sv
csr_file.sv
sys_exec.sv
csr_unit.sv
csr_unit_assertions.sv
csr_checker.sv
tb_csr_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_csr_unit -f csr_unit.f
out=$(./obj_dir/Vtb_csr_unit)
echo "$out"
echo "$out" | grep -q "=== PASS ==="
